// ==== flist.f ====
source/cpu_pkg.sv
source/decode_execute_if.sv
source/register_file.sv
source/instruction_decoder.sv
source/alu_execute.sv
source/decode_core.sv
tests/decode_core_properties.sv
tests/decode_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode_core testbench with Verilator
verilator --binary --assert --timescale 1ns/1ns -f flist.f \
   --top-module decode_core_tb -o decode_core_sim || exit 1
out=$(./obj_dir/decode_core_sim)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }

// ==== source/alu_execute.sv ====
`timescale 1ns/1ns

module alu_execute
   import cpu_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   decode_execute_if.sink        i_dx,
   output logic                  o_result_valid,
   output logic [REG_ADDR_W-1:0] o_result_dest,
   output logic [WORD_W-1:0]     o_result_value
);

   logic [WORD_W-1:0]  imm_ext;
   logic [WORD_W-1:0]  operand_b;
   logic [SHAMT_W-1:0] shift_amt;
   logic [WORD_W-1:0]  value;

   ////////////////////
   // Operand selection
   ////////////////////

   assign imm_ext = i_dx.sign_imm
                  ? {{(WORD_W-IMM_W){i_dx.immediate[IMM_W-1]}}, i_dx.immediate}
                  : {{(WORD_W-IMM_W){1'b0}}, i_dx.immediate};

   assign operand_b = i_dx.use_imm ? imm_ext : i_dx.operand_b;

   // Variable shifts take the low bits of rs
   assign shift_amt = i_dx.use_shamt ? i_dx.shamt : i_dx.operand_a[SHAMT_W-1:0];

   ////////////////////
   // ALU
   ////////////////////

   always_comb begin
      case (i_dx.alu_op)
         ALU_ADD: value = i_dx.operand_a + operand_b;
         ALU_SUB: value = i_dx.operand_a - operand_b;
         ALU_AND: value = i_dx.operand_a & operand_b;
         ALU_OR:  value = i_dx.operand_a | operand_b;
         ALU_XOR: value = i_dx.operand_a ^ operand_b;
         ALU_NOR: value = ~(i_dx.operand_a | operand_b);
         // Shifts always act on the rt word
         ALU_SRL: value = i_dx.operand_b >> shift_amt;
         ALU_SLL: value = i_dx.operand_b << shift_amt;
         ALU_SRA: value = $unsigned($signed(i_dx.operand_b) >>> shift_amt);
         ALU_SLT: begin
            value = {{(WORD_W-1){1'b0}},
                     $signed(i_dx.operand_a) < $signed(operand_b)};
         end
         ALU_LUI: value = {i_dx.immediate, {(WORD_W-IMM_W){1'b0}}};
         default: value = '0;
      endcase
   end

   ////////////////////
   // Result register
   ////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_result_valid <= 1'b0;
      end else begin
         o_result_valid <= i_dx.valid;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_dx.valid) begin
         o_result_dest  <= i_dx.dest;
         o_result_value <= value;
      end
   end

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

   ////////////////////
   // Widths
   ////////////////////

   localparam int WORD_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int REG_COUNT  = 32;
   localparam int IMM_W      = 16;
   localparam int SHAMT_W    = 5;
   localparam int OPCODE_W   = 6;
   localparam int FUNCT_W    = 6;
   localparam int ALU_OP_W   = 4;

   // Field positions, MSB of each field in the instruction word
   localparam int OPCODE_MSB = 31;
   localparam int RS_MSB     = 25;
   localparam int RT_MSB     = 20;
   localparam int RD_MSB     = 15;
   localparam int SHAMT_MSB  = 10;
   localparam int FUNCT_MSB  = 5;

   ////////////////////
   // Encodings
   ////////////////////

   // Only the ALU group of the opcode space
   typedef enum logic [OPCODE_W-1:0] {
      OP_R_TYPE = 6'b000000,
      OP_ADDI   = 6'b001001,
      OP_SLTI   = 6'b001010,
      OP_ANDI   = 6'b001100,
      OP_ORI    = 6'b001101,
      OP_XORI   = 6'b001110,
      OP_LUI    = 6'b001111
   } opcode_e;

   // R-type function codes
   typedef enum logic [FUNCT_W-1:0] {
      FN_SLL  = 6'b000000,
      FN_SRL  = 6'b000010,
      FN_SRA  = 6'b000011,
      FN_SLLV = 6'b000100,
      FN_SRLV = 6'b000110,
      FN_SRAV = 6'b000111,
      FN_ADDU = 6'b100001,
      FN_SUBU = 6'b100011,
      FN_AND  = 6'b100100,
      FN_OR   = 6'b100101,
      FN_XOR  = 6'b100110,
      FN_NOR  = 6'b100111,
      FN_SLT  = 6'b101010
   } funct_e;

   // Code 4'b1001 stays free
   typedef enum logic [ALU_OP_W-1:0] {
      ALU_ADD = 4'b0000,
      ALU_SUB = 4'b0001,
      ALU_AND = 4'b0010,
      ALU_OR  = 4'b0011,
      ALU_XOR = 4'b0100,
      ALU_NOR = 4'b0101,
      ALU_SRL = 4'b0110,
      ALU_SLL = 4'b0111,
      ALU_SRA = 4'b1000,
      ALU_SLT = 4'b1010,
      ALU_LUI = 4'b1011
   } alu_op_e;

endpackage

// ==== source/decode_core.sv ====
`timescale 1ns/1ns

module decode_core
   import cpu_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_instr_valid,
   input  logic [WORD_W-1:0]     i_instr,
   input  logic                  i_reg_we,
   input  logic [REG_ADDR_W-1:0] i_reg_addr,
   input  logic [WORD_W-1:0]     i_reg_data,
   output logic                  o_result_valid,
   output logic [REG_ADDR_W-1:0] o_result_dest,
   output logic [WORD_W-1:0]     o_result_value
);

   logic [REG_ADDR_W-1:0] raddr_a;
   logic [REG_ADDR_W-1:0] raddr_b;
   logic [WORD_W-1:0]     rdata_a;
   logic [WORD_W-1:0]     rdata_b;

   decode_execute_if dx ();

   // External write port only, no write-back
   register_file u_register_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_we      (i_reg_we),
      .i_waddr   (i_reg_addr),
      .i_wdata   (i_reg_data),
      .i_raddr_a (raddr_a),
      .i_raddr_b (raddr_b),
      .o_rdata_a (rdata_a),
      .o_rdata_b (rdata_b)
   );

   instruction_decoder u_instruction_decoder (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .o_raddr_a     (raddr_a),
      .o_raddr_b     (raddr_b),
      .i_rdata_a     (rdata_a),
      .i_rdata_b     (rdata_b),
      .o_dx          (dx.source)
   );

   alu_execute u_alu_execute (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_dx           (dx.sink),
      .o_result_valid (o_result_valid),
      .o_result_dest  (o_result_dest),
      .o_result_value (o_result_value)
   );

endmodule

// ==== source/decode_execute_if.sv ====
`timescale 1ns/1ns

// One decoded operation, valid for a single cycle
interface decode_execute_if
   import cpu_pkg::*;
();

   logic                  valid;
   alu_op_e               alu_op;
   logic [WORD_W-1:0]     operand_a;
   logic [WORD_W-1:0]     operand_b;
   logic [IMM_W-1:0]      immediate;
   logic [SHAMT_W-1:0]    shamt;
   logic                  use_imm;
   logic                  sign_imm;
   logic                  use_shamt;
   logic [REG_ADDR_W-1:0] dest;

   modport source (
      output valid, alu_op, operand_a, operand_b, immediate,
      output shamt, use_imm, sign_imm, use_shamt, dest
   );

   modport sink (
      input valid, alu_op, operand_a, operand_b, immediate,
      input shamt, use_imm, sign_imm, use_shamt, dest
   );

endinterface

// ==== source/instruction_decoder.sv ====
`timescale 1ns/1ns

module instruction_decoder
   import cpu_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_instr_valid,
   input  logic [WORD_W-1:0]     i_instr,
   output logic [REG_ADDR_W-1:0] o_raddr_a,
   output logic [REG_ADDR_W-1:0] o_raddr_b,
   input  logic [WORD_W-1:0]     i_rdata_a,
   input  logic [WORD_W-1:0]     i_rdata_b,
   decode_execute_if.source      o_dx
);

   opcode_e               opcode;
   funct_e                funct;
   logic [REG_ADDR_W-1:0] rs;
   logic [REG_ADDR_W-1:0] rt;
   logic [REG_ADDR_W-1:0] rd;
   logic [IMM_W-1:0]      imm;
   logic [SHAMT_W-1:0]    shamt;

   // Opcode table outputs
   logic    use_fn_table;
   logic    op_known;
   logic    use_imm;
   logic    sign_imm;
   alu_op_e op_alu;

   // Function table outputs
   logic    fn_known;
   logic    fn_shamt;
   alu_op_e fn_alu;

   logic                  decode_ok;
   alu_op_e               alu_op;
   logic [REG_ADDR_W-1:0] dest;

   // Field split
   assign opcode = opcode_e'(i_instr[OPCODE_MSB -: OPCODE_W]);
   assign funct  = funct_e'(i_instr[FUNCT_MSB -: FUNCT_W]);
   assign rs     = i_instr[RS_MSB -: REG_ADDR_W];
   assign rt     = i_instr[RT_MSB -: REG_ADDR_W];
   assign rd     = i_instr[RD_MSB -: REG_ADDR_W];
   assign shamt  = i_instr[SHAMT_MSB -: SHAMT_W];
   assign imm    = i_instr[IMM_W-1:0];

   assign o_raddr_a = rs;
   assign o_raddr_b = rt;

   ////////////////////
   // Opcode table
   ////////////////////

   always_comb begin
      use_fn_table = 1'b0;
      op_known     = 1'b1;
      use_imm      = 1'b1;
      sign_imm     = 1'b0;
      op_alu       = ALU_ADD;
      case (opcode)
         OP_R_TYPE: begin
            use_fn_table = 1'b1;
            use_imm      = 1'b0;
         end
         OP_ADDI: begin
            op_alu   = ALU_ADD;
            sign_imm = 1'b1;
         end
         OP_SLTI: begin
            op_alu   = ALU_SLT;
            sign_imm = 1'b1;
         end
         OP_ANDI: op_alu = ALU_AND;
         OP_ORI:  op_alu = ALU_OR;
         OP_XORI: op_alu = ALU_XOR;
         OP_LUI:  op_alu = ALU_LUI;
         // Loads, stores, branches, jumps and anything else
         default: begin
            op_known = 1'b0;
            use_imm  = 1'b0;
         end
      endcase
   end

   ////////////////////
   // Function table
   ////////////////////

   always_comb begin
      fn_known = 1'b1;
      fn_shamt = 1'b0;
      fn_alu   = ALU_ADD;
      case (funct)
         FN_SLL: begin
            fn_alu   = ALU_SLL;
            fn_shamt = 1'b1;
         end
         FN_SRL: begin
            fn_alu   = ALU_SRL;
            fn_shamt = 1'b1;
         end
         FN_SRA: begin
            fn_alu   = ALU_SRA;
            fn_shamt = 1'b1;
         end
         FN_SLLV: fn_alu = ALU_SLL;
         FN_SRLV: fn_alu = ALU_SRL;
         FN_SRAV: fn_alu = ALU_SRA;
         FN_ADDU: fn_alu = ALU_ADD;
         FN_SUBU: fn_alu = ALU_SUB;
         FN_AND:  fn_alu = ALU_AND;
         FN_OR:   fn_alu = ALU_OR;
         FN_XOR:  fn_alu = ALU_XOR;
         FN_NOR:  fn_alu = ALU_NOR;
         FN_SLT:  fn_alu = ALU_SLT;
         default: fn_known = 1'b0; // JR, JALR, unknown
      endcase
   end

   assign decode_ok = use_fn_table ? fn_known : op_known;
   assign alu_op    = use_fn_table ? fn_alu : op_alu;
   assign dest      = use_fn_table ? rd : rt;

   ////////////////////
   // Decoded-operation register
   ////////////////////

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_dx.valid <= 1'b0;
      end else begin
         o_dx.valid <= i_instr_valid & decode_ok;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_instr_valid) begin
         o_dx.alu_op    <= alu_op;
         o_dx.operand_a <= i_rdata_a;
         o_dx.operand_b <= i_rdata_b;
         o_dx.immediate <= imm;
         o_dx.shamt     <= shamt;
         o_dx.use_imm   <= use_imm;
         o_dx.sign_imm  <= sign_imm;
         o_dx.use_shamt <= use_fn_table & fn_shamt;
         o_dx.dest      <= dest;
      end
   end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ns

module register_file
   import cpu_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_we,
   input  logic [REG_ADDR_W-1:0] i_waddr,
   input  logic [WORD_W-1:0]     i_wdata,
   input  logic [REG_ADDR_W-1:0] i_raddr_a,
   input  logic [REG_ADDR_W-1:0] i_raddr_b,
   output logic [WORD_W-1:0]     o_rdata_a,
   output logic [WORD_W-1:0]     o_rdata_b
);

   logic [WORD_W-1:0] regs [REG_COUNT];

   ////////////////////
   // Write port
   ////////////////////

   // r0 is writable like any other entry
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   ////////////////////
   // Read ports
   ////////////////////

   // Same-cycle write is not forwarded, old value is read
   assign o_rdata_a = regs[i_raddr_a];
   assign o_rdata_b = regs[i_raddr_b];

endmodule

// ==== tests/alu_cases.txt ====
# W <reg> <data hex>
# I <name> <instr hex> <expected valid> <expected dest> <expected value hex>
I addu_zero 02954821 1 9 00000000
W 1 00000007
W 2 00000005
W 3 fffffff0
W 4 80000004
W 5 00000024
I addu 00225021 1 10 0000000c
I subu 00415823 1 11 fffffffe
I and 00226024 1 12 00000005
I or 00236825 1 13 fffffff7
I xor 00227026 1 14 00000002
I nor 00227827 1 15 fffffff8
I slt_neg 0061802a 1 16 00000001
I addi_neg 2432fffd 1 18 00000004
I slti_neg 2833ffff 1 19 00000000
I andi 30778f0f 1 23 00008f00
I ori 34388000 1 24 00008007
I xori 3879ffff 1 25 ffff000f
I lui 3c1a8001 1 26 80010000
I sll 0004d900 1 27 00000040
I srl 0004e202 1 28 00800000
I sra 0004ea03 1 29 ff800000
I srlv 00a4f806 1 31 08000000
I srav 00a44007 1 8 f8000000
I lw 8c220000 0 0 00000000
I sw ac220000 0 0 00000000
I beq 10220004 0 0 00000000
I j 08000010 0 0 00000000
I jr 00200008 0 0 00000000
I jalr 0020f809 0 0 00000000
I funct_bad 0022503f 0 0 00000000
W 6 12345678
I write_then_read 00d44821 1 9 12345678

// ==== tests/decode_core_properties.sv ====
`timescale 1ns/1ns

module decode_core_properties
   import cpu_pkg::*;
(
   input logic                  i_clk,
   input logic                  i_rst,
   input logic                  i_instr_valid,
   input logic                  i_result_valid,
   input logic [REG_ADDR_W-1:0] i_result_dest,
   input logic [WORD_W-1:0]     i_result_value
);

   int assert_failures = 0;

   // Result register cleared by reset
   assert property (@(posedge i_clk) $fell(i_rst) |-> !i_result_valid)
      else begin
         $error("result strobe high in the cycle after reset");
         assert_failures++;
      end

   // Fixed two-cycle latency from the instruction strobe
   assert property (@(posedge i_clk) disable iff (i_rst)
                    i_result_valid |-> $past(i_instr_valid, 2))
      else begin
         $error("result strobe without an instruction two cycles earlier");
         assert_failures++;
      end

   assert property (@(posedge i_clk) disable iff (i_rst)
                    i_result_valid |-> !$isunknown({i_result_dest, i_result_value}))
      else begin
         $error("unknown result while the result strobe is high");
         assert_failures++;
      end

endmodule

bind decode_core decode_core_properties u_decode_core_properties (
   .i_clk          (i_clk),
   .i_rst          (i_rst),
   .i_instr_valid  (i_instr_valid),
   .i_result_valid (o_result_valid),
   .i_result_dest  (o_result_dest),
   .i_result_value (o_result_value)
);

// ==== tests/decode_core_tb.sv ====
`timescale 1ns/1ns

module decode_core_tb
   import cpu_pkg::*;
();

   logic                  i_clk;
   logic                  i_rst;
   logic                  i_instr_valid;
   logic [WORD_W-1:0]     i_instr;
   logic                  i_reg_we;
   logic [REG_ADDR_W-1:0] i_reg_addr;
   logic [WORD_W-1:0]     i_reg_data;
   logic                  o_result_valid;
   logic [REG_ADDR_W-1:0] o_result_dest;
   logic [WORD_W-1:0]     o_result_value;

   // Cases kept for the back-to-back pass
   string                 case_name[$];
   logic [WORD_W-1:0]     case_instr[$];
   logic                  case_valid[$];
   logic [REG_ADDR_W-1:0] case_dest[$];
   logic [WORD_W-1:0]     case_value[$];

   int pass_count = 0;
   int fail_count = 0;
   int result_timeout = 8;

   decode_core dut (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_instr_valid  (i_instr_valid),
      .i_instr        (i_instr),
      .i_reg_we       (i_reg_we),
      .i_reg_addr     (i_reg_addr),
      .i_reg_data     (i_reg_data),
      .o_result_valid (o_result_valid),
      .o_result_dest  (o_result_dest),
      .o_result_value (o_result_value)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   task automatic report_test(input string name, input bit ok);
      if (ok) begin
         pass_count++;
      end else begin
         fail_count++;
      end
      $display("%s: %s", name, ok ? "passed" : "failed");
   endtask

   // Called 1 ns after a rising edge
   task automatic write_register(input logic [REG_ADDR_W-1:0] addr,
                                 input logic [WORD_W-1:0] data);
      i_reg_we   = 1'b1;
      i_reg_addr = addr;
      i_reg_data = data;
      @(posedge i_clk);
      #1;
      i_reg_we = 1'b0;
   endtask

   ////////////////////
   // One instruction at a time
   ////////////////////

   task automatic run_single_case(input string name, input logic [WORD_W-1:0] instr,
                                  input logic exp_valid, input logic [REG_ADDR_W-1:0] exp_dest,
                                  input logic [WORD_W-1:0] exp_value);
      bit ok;
      bit seen;
      int cycles;
      ok = 1'b1;
      seen = 1'b0;
      i_instr_valid = 1'b1;
      i_instr       = instr;
      @(posedge i_clk);
      #1;
      i_instr_valid = 1'b0;
      // Strobe edge counts as the first cycle
      cycles = 1;
      while (!seen && cycles < result_timeout) begin
         @(posedge i_clk);
         #1;
         cycles++;
         seen = o_result_valid;
      end
      if (exp_valid && !seen) begin
         $display("No result strobe for %s within %0d cycles", name, result_timeout);
         ok = 1'b0;
      end
      if (!exp_valid && seen) begin
         $display("[FAIL] %s valid: expected 0, got 1", name);
         ok = 1'b0;
      end
      if (exp_valid && seen && cycles != 2) begin
         $display("[FAIL] %s latency: expected 2, got %0d", name, cycles);
         ok = 1'b0;
      end
      if (exp_valid && seen && o_result_dest !== exp_dest) begin
         $display("[FAIL] %s dest: expected %0d, got %0d", name, exp_dest, o_result_dest);
         ok = 1'b0;
      end
      if (exp_valid && seen && o_result_value !== exp_value) begin
         $display("[FAIL] %s value: expected %08h, got %08h", name, exp_value, o_result_value);
         ok = 1'b0;
      end
      report_test(name, ok);
   endtask

   ////////////////////
   // Back-to-back issue
   ////////////////////

   task automatic run_back_to_back();
      int                    got_cycle[$];
      logic [REG_ADDR_W-1:0] got_dest[$];
      logic [WORD_W-1:0]     got_value[$];
      int                    cycle;
      int                    k;
      bit                    ok;
      string                 name;
      cycle = 0;
      k = 0;
      // Bounded collection, the last result is due two cycles after the last strobe
      while (cycle < case_instr.size() + 3) begin
         i_instr_valid = (cycle < case_instr.size());
         if (cycle < case_instr.size()) begin
            i_instr = case_instr[cycle];
         end
         @(posedge i_clk);
         #1;
         cycle++;
         if (o_result_valid === 1'b1) begin
            got_cycle.push_back(cycle);
            got_dest.push_back(o_result_dest);
            got_value.push_back(o_result_value);
         end
      end
      for (int j = 0; j < case_instr.size(); j++) begin
         if (case_valid[j]) begin
            ok = 1'b1;
            name = {case_name[j], "_b2b"};
            if (k >= got_cycle.size()) begin
               $display("No back-to-back result for %s before the timeout", name);
               ok = 1'b0;
            end else begin
               if (got_cycle[k] - j != 2) begin
                  $display("[FAIL] %s latency: expected 2, got %0d", name, got_cycle[k] - j);
                  ok = 1'b0;
               end
               if (got_dest[k] !== case_dest[j]) begin
                  $display("[FAIL] %s dest: expected %0d, got %0d", name, case_dest[j],
                           got_dest[k]);
                  ok = 1'b0;
               end
               if (got_value[k] !== case_value[j]) begin
                  $display("[FAIL] %s value: expected %08h, got %08h", name, case_value[j],
                           got_value[k]);
                  ok = 1'b0;
               end
            end
            k++;
            report_test(name, ok);
         end
      end
      if (k < got_cycle.size()) begin
         $display("Back-to-back run gave %0d more result strobes than expected",
                  got_cycle.size() - k);
         fail_count++;
      end
   endtask

   initial begin
      int                    fd;
      string                 line;
      string                 kind;
      string                 name;
      logic [REG_ADDR_W-1:0] addr;
      logic [WORD_W-1:0]     data;
      logic [WORD_W-1:0]     instr;
      logic                  exp_valid;
      logic [REG_ADDR_W-1:0] exp_dest;
      logic [WORD_W-1:0]     exp_value;
      i_rst         = 1'b1;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      i_reg_we      = 1'b0;
      i_reg_addr    = '0;
      i_reg_data    = '0;
      repeat (2) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      fd = $fopen("tests/alu_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open tests/alu_cases.txt");
         fail_count++;
      end else begin
         while ($fgets(line, fd) > 0) begin
            kind = "";
            void'($sscanf(line, "%s", kind));
            if (kind == "W") begin
               void'($sscanf(line, "%s %d %h", kind, addr, data));
               write_register(addr, data);
            end else if (kind == "I") begin
               void'($sscanf(line, "%s %s %h %d %d %h", kind, name, instr, exp_valid,
                             exp_dest, exp_value));
               case_name.push_back(name);
               case_instr.push_back(instr);
               case_valid.push_back(exp_valid);
               case_dest.push_back(exp_dest);
               case_value.push_back(exp_value);
               run_single_case(name, instr, exp_valid, exp_dest, exp_value);
            end
         end
         $fclose(fd);
         run_back_to_back();
      end
      if (dut.u_decode_core_properties.assert_failures != 0) begin
         $display("Bound assertions failed %0d times",
                  dut.u_decode_core_properties.assert_failures);
         fail_count++;
      end
      $display("Totals: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
